/* audio_pkt_settings.svh */
// audio packet settings
`ifndef AUDIO_PKT_SETTINGS_SVH
`define AUDIO_PKT_SETTINGS_SVH

// fifo address width, 1024 words deep
`define AUDIO_FIFO_AW 10

// flops per clock crossing synchronizer
`define AUDIO_SYNC_STAGES 2

// sync marker word, {payload size, sample step}
`define AUDIO_MARK_HI 16'd1000  // nominal payload bytes
`define AUDIO_MARK_LO 16'd48    // sample step code

`endif

/* audio_pkt_pkg.sv */
// audio packet types
`include "audio_pkt_settings.svh"

package audio_pkt_pkg;

  typedef logic [15:0] sample_t;      // one audio sample
  typedef logic [31:0] fifo_word_t;   // sample pair or sync marker

  // stored word count, one extra bit to reach full depth
  typedef logic [`AUDIO_FIFO_AW:0] fifo_level_t;

  typedef logic [15:0] byte_cnt_t;    // udp payload length in bytes
  typedef logic [10:0] pkt_cnt_t;     // sent packet counter

  // udp scheduler states
  typedef enum logic [1:0] {
    IDLE,       // transfer off
    WAIT_FILL,  // waiting for a packet's worth of words
    BUSY        // packet handed to the stack
  } sched_state_t;

endpackage

/* audio_sample_packer.sv */
// audio sample pair packer
`timescale 1ns/1ns
`include "audio_pkt_settings.svh"

module audio_sample_packer
  import audio_pkt_pkg::*;
(
  input  logic        audio_clk,
  input  logic        rst_n,
  input  logic        transfer_flag,
  input  logic        audio_en,
  input  sample_t     audio_data,
  input  fifo_level_t wr_level,
  output logic        wr_en,
  output fifo_word_t  wr_data,
  output logic        wr_rst
);

  logic [`AUDIO_SYNC_STAGES-1:0] flag_sync;  // transfer_flag into audio_clk
  logic    flag_on;
  logic    mark_pend;   // marker still owed this session
  logic    mark_go;
  logic    take;        // sample accepted this cycle
  logic    half;        // first sample of a pair is held
  sample_t first_smp;

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_sync <= '0;
    end else begin
      flag_sync <= {flag_sync[`AUDIO_SYNC_STAGES-2:0], transfer_flag};
    end
  end

  assign flag_on = flag_sync[`AUDIO_SYNC_STAGES-1];
  assign wr_rst  = ~flag_on;  // write side flushed while transfer is off

  // marker only once the write side is empty and idle
  assign mark_go = flag_on & mark_pend & (wr_level == '0);

  // samples before the marker goes out are dropped
  assign take = flag_on & audio_en & (~mark_pend | mark_go);

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      mark_pend <= 1'b1;
      half      <= 1'b0;
      wr_en     <= 1'b0;
    end else if (!flag_on) begin
      mark_pend <= 1'b1;  // rearm for the next session
      half      <= 1'b0;  // pairing restarts
      wr_en     <= 1'b0;
    end else begin
      if (mark_go) begin
        mark_pend <= 1'b0;
      end
      if (take) begin
        half <= ~half;
      end
      wr_en <= mark_go | (take & half);
    end
  end

  // pair payload, earlier sample in the upper half
  always_ff @(posedge audio_clk) begin
    if (take && !half) begin
      first_smp <= audio_data;
    end
    if (mark_go) begin
      wr_data <= {`AUDIO_MARK_HI, `AUDIO_MARK_LO};
    end else if (take && half) begin
      wr_data <= {first_smp, audio_data};
    end
  end

endmodule

/* audio_async_fifo.sv */
// dual clock gray pointer fifo
`timescale 1ns/1ns
`include "audio_pkt_settings.svh"

module audio_async_fifo
  import audio_pkt_pkg::*;
(
  input  logic        wr_clk,
  input  logic        wr_rst,
  input  logic        wr_en,
  input  fifo_word_t  wr_data,
  output fifo_level_t wr_level,
  input  logic        rd_clk,
  input  logic        rd_rst,
  input  logic        rd_en,
  output fifo_word_t  rd_data,
  output fifo_level_t rd_level,
  output logic        empty,
  input  logic        rst_n
);

  localparam int AW    = `AUDIO_FIFO_AW;
  localparam int DEPTH = 1 << AW;
  localparam int NS    = `AUDIO_SYNC_STAGES;

  typedef logic [AW:0] ptr_t;  // address plus wrap bit

  fifo_word_t mem [DEPTH];

  ptr_t wr_bin;
  ptr_t wr_bin_nxt;
  ptr_t wr_gray;
  ptr_t rd_bin;
  ptr_t rd_bin_nxt;
  ptr_t rd_gray;
  ptr_t rd_gray_ws [NS];  // read pointer as seen by the write side
  ptr_t wr_gray_rs [NS];  // write pointer as seen by the read side
  ptr_t rd_bin_ws;
  ptr_t wr_bin_rs;
  logic full;
  logic wr_ok;
  logic rd_ok;

  function automatic ptr_t gray2bin(input ptr_t g);
    ptr_t b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // write side
  assign rd_bin_ws  = gray2bin(rd_gray_ws[NS-1]);
  assign full       = (ptr_t'(wr_bin - rd_bin_ws) == ptr_t'(DEPTH));
  assign wr_ok      = wr_en & ~full;  // write on full is dropped
  assign wr_bin_nxt = wr_bin + ptr_t'(wr_ok);

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin   <= '0;
      wr_gray  <= '0;
      wr_level <= '0;
      for (int i = 0; i < NS; i++) begin
        rd_gray_ws[i] <= '0;
      end
    end else if (wr_rst) begin
      wr_bin   <= '0;
      wr_gray  <= '0;
      wr_level <= '0;
      for (int i = 0; i < NS; i++) begin
        rd_gray_ws[i] <= '0;
      end
    end else begin
      wr_bin   <= wr_bin_nxt;
      wr_gray  <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      wr_level <= fifo_level_t'(wr_bin_nxt - rd_bin_ws);
      rd_gray_ws[0] <= rd_gray;
      for (int i = 1; i < NS; i++) begin
        rd_gray_ws[i] <= rd_gray_ws[i-1];
      end
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_ok) begin
      mem[wr_bin[AW-1:0]] <= wr_data;
    end
  end

  // read side
  assign wr_bin_rs  = gray2bin(wr_gray_rs[NS-1]);
  assign empty      = (wr_bin_rs == rd_bin);
  assign rd_ok      = rd_en & ~empty;  // read on empty is ignored
  assign rd_bin_nxt = rd_bin + ptr_t'(rd_ok);

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin   <= '0;
      rd_gray  <= '0;
      rd_level <= '0;
      for (int i = 0; i < NS; i++) begin
        wr_gray_rs[i] <= '0;
      end
    end else if (rd_rst) begin
      rd_bin   <= '0;
      rd_gray  <= '0;
      rd_level <= '0;
      for (int i = 0; i < NS; i++) begin
        wr_gray_rs[i] <= '0;
      end
    end else begin
      rd_bin   <= rd_bin_nxt;
      rd_gray  <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      rd_level <= fifo_level_t'(wr_bin_rs - rd_bin_nxt);  // counts this cycle's read
      wr_gray_rs[0] <= wr_gray;
      for (int i = 1; i < NS; i++) begin
        wr_gray_rs[i] <= wr_gray_rs[i-1];
      end
    end
  end

  // data one rd_clk after the request
  always_ff @(posedge rd_clk) begin
    if (rd_ok) begin
      rd_data <= mem[rd_bin[AW-1:0]];
    end
  end

endmodule

/* udp_tx_scheduler.sv */
// udp packet start scheduler
`timescale 1ns/1ns
`include "audio_pkt_settings.svh"

module udp_tx_scheduler
  import audio_pkt_pkg::*;
(
  input  logic        eth_tx_clk,
  input  logic        rst_n,
  input  logic        transfer_flag,
  input  byte_cnt_t   pkt_words,
  input  fifo_level_t rd_level,
  input  logic        udp_tx_done,
  output logic        rd_rst,
  output logic        udp_tx_start_en,
  output byte_cnt_t   udp_tx_byte_num,
  output pkt_cnt_t    udp_pkt_cnt
);

  logic [`AUDIO_SYNC_STAGES-1:0] flag_sync;  // transfer_flag into eth_tx_clk
  logic         flag_on;
  logic         fill_ok;
  sched_state_t state;

  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_sync <= '0;
    end else begin
      flag_sync <= {flag_sync[`AUDIO_SYNC_STAGES-2:0], transfer_flag};
    end
  end

  assign flag_on = flag_sync[`AUDIO_SYNC_STAGES-1];
  assign rd_rst  = ~flag_on;  // read side flushed with the flag

  // a full packet is stored, empty packets never start
  assign fill_ok = (pkt_words != '0) && (byte_cnt_t'(rd_level) >= pkt_words);

  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= IDLE;
      udp_tx_start_en <= 1'b0;
      udp_tx_byte_num <= '0;
    end else if (!flag_on) begin
      state           <= IDLE;
      udp_tx_start_en <= 1'b0;
      udp_tx_byte_num <= '0;
    end else begin
      udp_tx_start_en <= 1'b0;  // single cycle pulse
      case (state)
        IDLE: begin
          state <= WAIT_FILL;
        end
        WAIT_FILL: begin
          if (fill_ok) begin
            udp_tx_start_en <= 1'b1;
            udp_tx_byte_num <= {pkt_words[13:0], 2'b00};  // four bytes per word
            state           <= BUSY;
          end
        end
        BUSY: begin
          // byte count held until the stack is done
          if (udp_tx_done) begin
            state <= WAIT_FILL;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // packets sent, kept across sessions
  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      udp_pkt_cnt <= '0;
    end else if (udp_tx_done) begin
      udp_pkt_cnt <= udp_pkt_cnt + pkt_cnt_t'(1);
    end
  end

endmodule

/* audio_udp_top.sv */
// audio to udp packing top
`timescale 1ns/1ns

module audio_udp_top
  import audio_pkt_pkg::*;
(
  input  logic       rst_n,
  input  logic       audio_clk,
  input  logic       eth_tx_clk,
  input  logic       transfer_flag,
  input  logic       audio_en,
  input  sample_t    audio_data,
  input  byte_cnt_t  pkt_words,
  input  logic       udp_tx_req,
  input  logic       udp_tx_done,
  output logic       udp_tx_start_en,
  output fifo_word_t udp_tx_data,
  output byte_cnt_t  udp_tx_byte_num,
  output pkt_cnt_t   udp_pkt_cnt
);

  // audio_clk domain
  logic        wr_en;
  fifo_word_t  wr_data;
  logic        wr_rst;
  fifo_level_t wr_level;

  // eth_tx_clk domain
  logic        rd_rst;
  fifo_level_t rd_level;

  audio_sample_packer u_packer (
    .audio_clk     (audio_clk),
    .rst_n         (rst_n),
    .transfer_flag (transfer_flag),
    .audio_en      (audio_en),
    .audio_data    (audio_data),
    .wr_level      (wr_level),
    .wr_en         (wr_en),
    .wr_data       (wr_data),
    .wr_rst        (wr_rst)
  );

  audio_async_fifo u_fifo (
    .wr_clk   (audio_clk),
    .wr_rst   (wr_rst),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .wr_level (wr_level),
    .rd_clk   (eth_tx_clk),
    .rd_rst   (rd_rst),
    .rd_en    (udp_tx_req),   // stack reads straight from the fifo
    .rd_data  (udp_tx_data),
    .rd_level (rd_level),
    .empty    (),
    .rst_n    (rst_n)
  );

  udp_tx_scheduler u_sched (
    .eth_tx_clk      (eth_tx_clk),
    .rst_n           (rst_n),
    .transfer_flag   (transfer_flag),
    .pkt_words       (pkt_words),
    .rd_level        (rd_level),
    .udp_tx_done     (udp_tx_done),
    .rd_rst          (rd_rst),
    .udp_tx_start_en (udp_tx_start_en),
    .udp_tx_byte_num (udp_tx_byte_num),
    .udp_pkt_cnt     (udp_pkt_cnt)
  );

endmodule

/* audio_udp_props.sv */
// udp packer assertions
`timescale 1ns/1ns
`include "audio_pkt_settings.svh"

module audio_udp_props
  import audio_pkt_pkg::*;
(
  input logic        audio_clk,
  input logic        eth_tx_clk,
  input logic        rst_n,
  input logic        udp_tx_start_en,
  input logic        udp_tx_done,
  input byte_cnt_t   udp_tx_byte_num,
  input logic        wr_en,
  input fifo_level_t wr_level
);

  localparam fifo_level_t FULL_LEVEL = fifo_level_t'(1 << `AUDIO_FIFO_AW);

  logic busy;  // packet between start and done

  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (udp_tx_start_en) begin
      busy <= 1'b1;
    end else if (udp_tx_done) begin
      busy <= 1'b0;
    end
  end

  start_one_cycle: assert property (@(posedge eth_tx_clk) disable iff (!rst_n)
    udp_tx_start_en |=> !udp_tx_start_en)
    else $error("udp_tx_start_en held longer than one cycle");

  no_start_busy: assert property (@(posedge eth_tx_clk) disable iff (!rst_n)
    busy |-> !udp_tx_start_en)
    else $error("start issued before udp_tx_done");

  no_write_full: assert property (@(posedge audio_clk) disable iff (!rst_n)
    wr_en |-> (wr_level != FULL_LEVEL))
    else $error("fifo write while full");

  byte_num_stable: assert property (@(posedge eth_tx_clk) disable iff (!rst_n)
    (busy && !udp_tx_done) |=> $stable(udp_tx_byte_num))
    else $error("udp_tx_byte_num changed during a packet");

endmodule

bind audio_udp_top audio_udp_props u_props (
  .audio_clk       (audio_clk),
  .eth_tx_clk      (eth_tx_clk),
  .rst_n           (rst_n),
  .udp_tx_start_en (udp_tx_start_en),
  .udp_tx_done     (udp_tx_done),
  .udp_tx_byte_num (udp_tx_byte_num),
  .wr_en           (wr_en),
  .wr_level        (wr_level)
);

/* tb_audio_udp.sv */
// audio udp packer testbench
`timescale 1ns/1ns

module tb_audio_udp;
  import audio_pkt_pkg::*;

  localparam int AUDIO_HALF  = 2;      // 4 ns audio_clk
  localparam int ETH_HALF    = 3;      // 6 ns eth_tx_clk
  localparam int READ_GAP    = 2;      // eth cycles per read request
  localparam int TIMEOUT_CYC = 20000;  // audio_clk cycles
  localparam fifo_word_t MARKER = {16'd1000, 16'd48};

  logic       rst_n;
  logic       audio_clk;
  logic       eth_tx_clk;
  logic       transfer_flag;
  logic       audio_en;
  sample_t    audio_data;
  byte_cnt_t  pkt_words;
  logic       udp_tx_req;
  logic       udp_tx_done;
  logic       udp_tx_start_en;
  fifo_word_t udp_tx_data;
  byte_cnt_t  udp_tx_byte_num;
  pkt_cnt_t   udp_pkt_cnt;

  fifo_word_t ref_q[$];  // words the stack should see, in order
  logic       session_on;
  pkt_cnt_t   exp_pkts;
  int         err_cnt;
  int         check_cnt;
  int         test_cnt;
  int         cycle_cnt;
  int         start_cnt;

  audio_udp_top DUT (
    .rst_n           (rst_n),
    .audio_clk       (audio_clk),
    .eth_tx_clk      (eth_tx_clk),
    .transfer_flag   (transfer_flag),
    .audio_en        (audio_en),
    .audio_data      (audio_data),
    .pkt_words       (pkt_words),
    .udp_tx_req      (udp_tx_req),
    .udp_tx_done     (udp_tx_done),
    .udp_tx_start_en (udp_tx_start_en),
    .udp_tx_data     (udp_tx_data),
    .udp_tx_byte_num (udp_tx_byte_num),
    .udp_pkt_cnt     (udp_pkt_cnt)
  );

  always #AUDIO_HALF audio_clk = ~audio_clk;
  always #ETH_HALF eth_tx_clk = ~eth_tx_clk;

  always @(posedge audio_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("run timed out after %0d audio_clk cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // start pulses seen, sampled mid cycle
  always @(negedge eth_tx_clk) begin
    if (udp_tx_start_en) begin
      start_cnt = start_cnt + 1;
    end
  end

  task automatic check_word(input string name, input fifo_word_t got, input fifo_word_t want);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("Error %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_bytes(input string name, input byte_cnt_t got, input byte_cnt_t want);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("Error %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_count(input string name, input pkt_cnt_t got, input pkt_cnt_t want);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("Error %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("Error %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // one strobe every other audio_clk, pairs go to the reference
  task automatic send_samples(input int n);
    sample_t s;
    sample_t first;
    for (int i = 0; i < n; i++) begin
      s = sample_t'($urandom);
      @(posedge audio_clk);
      #1;
      audio_en   = 1'b1;
      audio_data = s;
      if (i % 2 == 0) begin
        first = s;
      end else if (session_on) begin
        ref_q.push_back({first, s});  // earlier sample on top
      end
      @(posedge audio_clk);
      #1;
      audio_en = 1'b0;
    end
  endtask

  // udp stack model for one packet
  task automatic serve_packet(input byte_cnt_t exp_bytes, input int done_delay);
    int         nwords;
    fifo_word_t want;
    do begin
      @(posedge eth_tx_clk);
      #1;
    end while (!udp_tx_start_en);
    check_bytes("udp_tx_byte_num", udp_tx_byte_num, exp_bytes);
    nwords = int'(udp_tx_byte_num) / 4;
    for (int i = 0; i < nwords; i++) begin
      udp_tx_req = 1'b1;
      @(posedge eth_tx_clk);
      #1;
      udp_tx_req = 1'b0;
      if (ref_q.size() == 0) begin
        err_cnt++;
        $display("packet word %0d arrived with no expected word left", i);
      end else begin
        want = ref_q.pop_front();
        check_word("udp_tx_data", udp_tx_data, want);
      end
      repeat (READ_GAP - 1) begin
        @(posedge eth_tx_clk);
        #1;
      end
    end
    repeat (done_delay) begin
      @(posedge eth_tx_clk);
      #1;
    end
    check_bytes("udp_tx_byte_num", udp_tx_byte_num, exp_bytes);  // held until done
    udp_tx_done = 1'b1;
    @(posedge eth_tx_clk);
    #1;
    udp_tx_done = 1'b0;
    exp_pkts++;
    check_count("udp_pkt_cnt", udp_pkt_cnt, exp_pkts);
  endtask

  task automatic start_session();
    @(posedge audio_clk);
    #1;
    transfer_flag = 1'b1;
    repeat (6) @(posedge audio_clk);  // marker goes out meanwhile
    session_on = 1'b1;
    ref_q.push_back(MARKER);
  endtask

  task automatic test_reset_values();
    int errs_before;
    errs_before = err_cnt;
    check_bit("udp_tx_start_en", udp_tx_start_en, 1'b0);
    check_bytes("udp_tx_byte_num", udp_tx_byte_num, 16'd0);
    check_count("udp_pkt_cnt", udp_pkt_cnt, 11'd0);
    report_test("reset values", errs_before);
  endtask

  task automatic test_flag_low();
    int errs_before;
    int starts;
    errs_before = err_cnt;
    starts = start_cnt;
    send_samples(16);
    repeat (20) @(posedge eth_tx_clk);
    if (start_cnt != starts) begin
      err_cnt++;
      $display("start pulse seen while transfer_flag was low");
    end
    report_test("no start with flag low", errs_before);
  endtask

  task automatic test_first_packet();
    int errs_before;
    errs_before = err_cnt;
    start_session();
    fork
      send_samples(14);
      serve_packet(16'd32, 0);
    join
    report_test("first packet with marker", errs_before);
  endtask

  task automatic test_back_to_back();
    int errs_before;
    errs_before = err_cnt;
    fork
      send_samples(48);
      begin
        repeat (3) serve_packet(16'd32, 5);  // stack holds done back
      end
    join
    report_test("back to back packets", errs_before);
  endtask

  task automatic test_size_change();
    int errs_before;
    errs_before = err_cnt;
    fork
      send_samples(48);
      begin
        serve_packet(16'd32, 0);
        pkt_words = 16'd4;
        serve_packet(16'd16, 0);
        pkt_words = 16'd12;
        serve_packet(16'd48, 0);
      end
    join
    report_test("packet size change", errs_before);
  endtask

  task automatic test_restart();
    int errs_before;
    errs_before = err_cnt;
    pkt_words = 16'd8;
    send_samples(10);  // leftovers below one packet
    repeat (10) @(posedge audio_clk);
    #1;
    transfer_flag = 1'b0;
    session_on    = 1'b0;
    ref_q.delete();
    repeat (10) @(posedge audio_clk);
    check_bit("udp_tx_start_en", udp_tx_start_en, 1'b0);
    check_bytes("udp_tx_byte_num", udp_tx_byte_num, 16'd0);
    check_count("udp_pkt_cnt", udp_pkt_cnt, exp_pkts);  // kept over sessions
    start_session();
    fork
      send_samples(14);
      serve_packet(16'd32, 2);
    join
    report_test("session restart", errs_before);
  endtask

  initial begin
    void'($urandom(8));
    audio_clk     = 1'b0;
    eth_tx_clk    = 1'b0;
    rst_n         = 1'b0;
    transfer_flag = 1'b0;
    audio_en      = 1'b0;
    audio_data    = '0;
    pkt_words     = 16'd8;
    udp_tx_req    = 1'b0;
    udp_tx_done   = 1'b0;
    session_on    = 1'b0;
    exp_pkts      = '0;
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    cycle_cnt     = 0;
    start_cnt     = 0;
    repeat (2) @(posedge audio_clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge audio_clk);
    test_reset_values();
    test_flag_low();
    test_first_packet();
    test_back_to_back();
    test_size_change();
    test_restart();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
audio_pkt_pkg.sv
audio_sample_packer.sv
audio_async_fifo.sv
udp_tx_scheduler.sv
audio_udp_top.sv
audio_udp_props.sv
tb_audio_udp.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_audio_udp
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FLIST)) audio_pkt_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
